/* logic/ex1_settings.svh */
`ifndef EX1_SETTINGS_SVH
`define EX1_SETTINGS_SVH

// datapath width
`define EX1_XLEN 32

// architectural register index
`define EX1_REG_BITS 5

// in-flight results visible to ex1
// ex2 slot 0 is the younger of the two
`define EX1_EX2_SLOTS 2
`define EX1_WB_SLOTS 3

// loaded into both lanes on flush and reset
// andi r0, r0, 0
`define EX1_INST_NOP 32'h0340_0000

`endif

/* logic/ex1_pkg.sv */
`include "ex1_settings.svh"

package ex1_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic      en;
        logic      store;
        mem_size_e size;
        logic      atomic;
    } mem_op_t;

    // one decoded instruction with its register file operands
    typedef struct packed {
        logic [`EX1_XLEN-1:0]     pc;
        logic [31:0]              inst;
        logic [`EX1_REG_BITS-1:0] rj;
        logic [`EX1_REG_BITS-1:0] rk;
        logic [`EX1_REG_BITS-1:0] rd;
        logic [`EX1_XLEN-1:0]     rj_data;
        logic [`EX1_XLEN-1:0]     rk_data;
        logic [`EX1_XLEN-1:0]     imm;
        mem_op_t                  mem_op;
    } lane_t;

    typedef struct packed {
        logic [`EX1_REG_BITS-1:0] rd;
        logic [`EX1_XLEN-1:0]     data;
        logic                     ready;
    } bypass_t;

    typedef struct packed {
        logic        valid;
        lane_t [1:0] lane;
    } issue_t;

    typedef struct packed {
        logic [`EX1_XLEN-1:0] rj_data;
        logic [`EX1_XLEN-1:0] rk_data;
        logic                 rj_fwd;
        logic                 rk_fwd;
        logic                 stall;
    } fwd_t;

    // lanes carry resolved operands here
    typedef struct packed {
        logic        valid;
        lane_t [1:0] lane;
    } ex1_out_t;

    typedef struct packed {
        logic                 valid;
        logic                 store;
        logic [3:0]           strb;
        logic [`EX1_XLEN-1:0] addr;
        logic [`EX1_XLEN-1:0] wdata;
        logic                 atomic;
    } dreq_t;

endpackage

/* logic/ex1_operand_forward.sv */
`timescale 1ns/1ps
`include "ex1_settings.svh"

module ex1_operand_forward (
    input  ex1_pkg::lane_t                         lane_i,
    input  ex1_pkg::bypass_t [`EX1_EX2_SLOTS-1:0] ex2_byp_i,
    input  ex1_pkg::bypass_t [`EX1_WB_SLOTS-1:0]  wb_byp_i,
    output ex1_pkg::fwd_t                          fwd_o
);

    localparam int NUM_SLOTS = `EX1_EX2_SLOTS + `EX1_WB_SLOTS;

    typedef struct packed {
        logic [`EX1_XLEN-1:0] data;
        logic                 hit_ready;
        logic                 hit_busy;
    } src_res_t;

    // priority order is index order: ex2 slots first, then wb slots
    ex1_pkg::bypass_t [NUM_SLOTS-1:0] slots;
    src_res_t                         res_j;
    src_res_t                         res_k;

    assign slots = {wb_byp_i, ex2_byp_i};

    function automatic src_res_t resolve(
        input logic [`EX1_REG_BITS-1:0]         idx,
        input logic [`EX1_XLEN-1:0]             rf_data,
        input ex1_pkg::bypass_t [NUM_SLOTS-1:0] byp
    );
        src_res_t res;
        res.data      = rf_data;
        res.hit_ready = 1'b0;
        res.hit_busy  = 1'b0;
        // scan from lowest priority up, the last match standing wins
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (idx != '0 && byp[i].rd == idx) begin
                res.hit_ready = byp[i].ready;
                res.hit_busy  = ~byp[i].ready;
                res.data      = byp[i].ready ? byp[i].data : rf_data;
            end
        end
        return res;
    endfunction

    always_comb begin
        res_j = resolve(lane_i.rj, lane_i.rj_data, slots);
        res_k = resolve(lane_i.rk, lane_i.rk_data, slots);
    end

    assign fwd_o.rj_data = res_j.data;
    assign fwd_o.rk_data = res_k.data;
    assign fwd_o.rj_fwd  = res_j.hit_ready;
    assign fwd_o.rk_fwd  = res_k.hit_ready;

    // a hit on a result still being computed holds the lane
    assign fwd_o.stall = res_j.hit_busy | res_k.hit_busy;

    // one register index cannot be forwarded and waited on at once
    always_comb begin
        assert (!(fwd_o.stall && (fwd_o.rj_fwd || fwd_o.rk_fwd) && lane_i.rj == lane_i.rk))
            else $error("ex1_operand_forward: source both forwarded and stalled");
    end

endmodule

/* logic/ex1_stage_buffer.sv */
`timescale 1ns/1ps
`include "ex1_settings.svh"

module ex1_stage_buffer (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              flush_i,
    input  ex1_pkg::issue_t   issue_i,
    input  ex1_pkg::fwd_t     fwd0_i,
    input  ex1_pkg::fwd_t     fwd1_i,
    input  logic              ex2_allowin_i,
    output logic              allowin_o,
    output logic              ready_go_o,
    output logic              stall_o,
    output ex1_pkg::dreq_t    dreq_o,
    output ex1_pkg::ex1_out_t ex1_out_o
);

    logic              stall_any;
    logic              transfer;
    logic              flush_take;
    ex1_pkg::lane_t    lane0;
    ex1_pkg::ex1_out_t out_d;
    ex1_pkg::ex1_out_t nop_pkt;
    ex1_pkg::ex1_out_t out_q;

    assign stall_any  = fwd0_i.stall | fwd1_i.stall;
    assign stall_o    = stall_any;
    assign ready_go_o = ~stall_any;
    assign allowin_o  = ex2_allowin_i;

    assign transfer   = issue_i.valid & allowin_o & ready_go_o;
    // flush only lands when ex2 is taking
    assign flush_take = flush_i & ex2_allowin_i;

    assign lane0 = issue_i.lane[0];

    // cache request, lane 0 only
    always_comb begin
        dreq_o.valid  = transfer & lane0.mem_op.en;
        dreq_o.store  = lane0.mem_op.store;
        dreq_o.atomic = lane0.mem_op.atomic;
        dreq_o.addr   = fwd0_i.rj_data + lane0.imm;
        dreq_o.wdata  = fwd0_i.rk_data;
        case (lane0.mem_op.size)
            ex1_pkg::MEM_BYTE: dreq_o.strb = 4'b0001;
            ex1_pkg::MEM_HALF: dreq_o.strb = 4'b0011;
            default:           dreq_o.strb = 4'b1111;
        endcase
    end

    // packet with resolved operands swapped in
    always_comb begin
        out_d.valid           = issue_i.valid;
        out_d.lane            = issue_i.lane;
        out_d.lane[0].rj_data = fwd0_i.rj_data;
        out_d.lane[0].rk_data = fwd0_i.rk_data;
        out_d.lane[1].rj_data = fwd1_i.rj_data;
        out_d.lane[1].rk_data = fwd1_i.rk_data;
    end

    always_comb begin
        nop_pkt              = '0;
        nop_pkt.lane[0].inst = `EX1_INST_NOP;
        nop_pkt.lane[1].inst = `EX1_INST_NOP;
    end

    // flush beats transfer
    always_ff @(posedge clk) begin
        if (reset_i || flush_take) begin
            out_q <= nop_pkt;
        end else if (transfer) begin
            out_q <= out_d;
        end
    end

    assign ex1_out_o = out_q;

    // a memory request is always followed by its packet in ex2
    assert property (@(posedge clk) disable iff (reset_i)
        dreq_o.valid && !flush_take |=> ex1_out_o.valid && ex1_out_o.lane[0].mem_op.en)
        else $error("ex1_stage_buffer: cache request without ex2 packet");

    // back-pressure freezes the ex2 register
    assert property (@(posedge clk) disable iff (reset_i)
        !ex2_allowin_i |=> $stable(ex1_out_o))
        else $error("ex1_stage_buffer: ex1_out_o moved under back-pressure");

endmodule

/* logic/ex1_stage.sv */
`timescale 1ns/1ps
`include "ex1_settings.svh"

module ex1_stage (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   flush_i,
    input  ex1_pkg::issue_t                        issue_i,
    input  ex1_pkg::bypass_t [`EX1_EX2_SLOTS-1:0] ex2_byp_i,
    input  ex1_pkg::bypass_t [`EX1_WB_SLOTS-1:0]  wb_byp_i,
    input  logic                                   ex2_allowin_i,
    output logic                                   allowin_o,
    output logic                                   ready_go_o,
    output logic                                   stall_o,
    output ex1_pkg::dreq_t                         dreq_o,
    output ex1_pkg::ex1_out_t                      ex1_out_o
);

    ex1_pkg::fwd_t fwd0;
    ex1_pkg::fwd_t fwd1;

    // one forwarding unit per lane, same slots for both
    ex1_operand_forward fwd_lane0 (
        .lane_i    (issue_i.lane[0]),
        .ex2_byp_i (ex2_byp_i),
        .wb_byp_i  (wb_byp_i),
        .fwd_o     (fwd0)
    );

    ex1_operand_forward fwd_lane1 (
        .lane_i    (issue_i.lane[1]),
        .ex2_byp_i (ex2_byp_i),
        .wb_byp_i  (wb_byp_i),
        .fwd_o     (fwd1)
    );

    ex1_stage_buffer buf0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .issue_i       (issue_i),
        .fwd0_i        (fwd0),
        .fwd1_i        (fwd1),
        .ex2_allowin_i (ex2_allowin_i),
        .allowin_o     (allowin_o),
        .ready_go_o    (ready_go_o),
        .stall_o       (stall_o),
        .dreq_o        (dreq_o),
        .ex1_out_o     (ex1_out_o)
    );

endmodule

/* dv/ex1_stage_tb.sv */
`timescale 1ns/1ps
`include "ex1_settings.svh"

module ex1_stage_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES   = 2000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

    logic                                   clk;
    logic                                   reset_i;
    logic                                   flush_i;
    ex1_pkg::issue_t                        issue_i;
    ex1_pkg::bypass_t [`EX1_EX2_SLOTS-1:0] ex2_byp_i;
    ex1_pkg::bypass_t [`EX1_WB_SLOTS-1:0]  wb_byp_i;
    logic                                   ex2_allowin_i;
    logic                                   allowin_o;
    logic                                   ready_go_o;
    logic                                   stall_o;
    ex1_pkg::dreq_t                         dreq_o;
    ex1_pkg::ex1_out_t                      ex1_out_o;

    integer            seed;
    int                errors;
    int                n_transfer;
    int                n_stall;
    int                n_flush;
    ex1_pkg::fwd_t     exp_fwd [2];
    ex1_pkg::dreq_t    exp_dreq;
    ex1_pkg::ex1_out_t exp_out;
    ex1_pkg::ex1_out_t nop_pkt;
    logic              exp_stall;
    logic              exp_transfer;

    ex1_stage dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .issue_i       (issue_i),
        .ex2_byp_i     (ex2_byp_i),
        .wb_byp_i      (wb_byp_i),
        .ex2_allowin_i (ex2_allowin_i),
        .allowin_o     (allowin_o),
        .ready_go_o    (ready_go_o),
        .stall_o       (stall_o),
        .dreq_o        (dreq_o),
        .ex1_out_o     (ex1_out_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        $display("FAIL time=%0t signal=%s expected=%s actual=%s", $time, name, exp_s, act_s);
        errors++;
    endtask

    // indices 0..7 so that slots match often
    task automatic random_lane(output ex1_pkg::lane_t lane);
        logic [31:0] r;
        r            = rand32();
        lane.pc      = rand32();
        lane.inst    = rand32();
        lane.rj      = {2'b00, r[2:0]};
        lane.rk      = {2'b00, r[5:3]};
        lane.rd      = {2'b00, r[8:6]};
        lane.rj_data = rand32();
        lane.rk_data = rand32();
        lane.imm     = rand32();
        lane.mem_op.en     = r[9];
        lane.mem_op.store  = r[10];
        lane.mem_op.atomic = r[11];
        lane.mem_op.size   = ex1_pkg::mem_size_e'((r[13:12] == 2'd3) ? 2'd2 : r[13:12]);
    endtask

    task automatic random_bypass(output ex1_pkg::bypass_t b);
        logic [31:0] r;
        r       = rand32();
        b.rd    = {2'b00, r[2:0]};
        b.ready = (r[4:3] != 2'b00);
        b.data  = rand32();
    endtask

    // first match in ex2 0, ex2 1, wb 0..2 order wins, r0 never matches
    task automatic resolve_source(
        input  logic [`EX1_REG_BITS-1:0] idx,
        input  logic [`EX1_XLEN-1:0]     rf_data,
        output logic [`EX1_XLEN-1:0]     data,
        output logic                     fwd,
        output logic                     busy
    );
        ex1_pkg::bypass_t order [`EX1_EX2_SLOTS + `EX1_WB_SLOTS];
        logic             found;
        for (int i = 0; i < `EX1_EX2_SLOTS; i++) order[i] = ex2_byp_i[i];
        for (int i = 0; i < `EX1_WB_SLOTS; i++) order[`EX1_EX2_SLOTS + i] = wb_byp_i[i];
        found = 1'b0;
        data  = rf_data;
        fwd   = 1'b0;
        busy  = 1'b0;
        if (idx != '0) begin
            for (int i = 0; i < `EX1_EX2_SLOTS + `EX1_WB_SLOTS; i++) begin
                if (!found && order[i].rd == idx) begin
                    found = 1'b1;
                    if (order[i].ready) begin
                        data = order[i].data;
                        fwd  = 1'b1;
                    end else begin
                        busy = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic compute_expected();
        logic [`EX1_XLEN-1:0] dj;
        logic [`EX1_XLEN-1:0] dk;
        logic                 fj;
        logic                 fk;
        logic                 bj;
        logic                 bk;
        ex1_pkg::lane_t       l0;
        exp_stall = 1'b0;
        for (int l = 0; l < 2; l++) begin
            resolve_source(issue_i.lane[l].rj, issue_i.lane[l].rj_data, dj, fj, bj);
            resolve_source(issue_i.lane[l].rk, issue_i.lane[l].rk_data, dk, fk, bk);
            exp_fwd[l].rj_data = dj;
            exp_fwd[l].rk_data = dk;
            exp_fwd[l].rj_fwd  = fj;
            exp_fwd[l].rk_fwd  = fk;
            exp_fwd[l].stall   = bj | bk;
            exp_stall          = exp_stall | bj | bk;
        end
        exp_transfer = issue_i.valid & ex2_allowin_i & ~exp_stall;
        l0 = issue_i.lane[0];
        exp_dreq.valid  = exp_transfer & l0.mem_op.en;
        exp_dreq.store  = l0.mem_op.store;
        exp_dreq.atomic = l0.mem_op.atomic;
        exp_dreq.addr   = exp_fwd[0].rj_data + l0.imm;
        exp_dreq.wdata  = exp_fwd[0].rk_data;
        case (l0.mem_op.size)
            ex1_pkg::MEM_BYTE: exp_dreq.strb = 4'b0001;
            ex1_pkg::MEM_HALF: exp_dreq.strb = 4'b0011;
            ex1_pkg::MEM_WORD: exp_dreq.strb = 4'b1111;
            default:           exp_dreq.strb = 4'b0000;
        endcase
    endtask

    task automatic check_flags(input string unit, input ex1_pkg::fwd_t act,
                               input ex1_pkg::fwd_t exp);
        if (act.rj_fwd !== exp.rj_fwd)
            report_mismatch({unit, ".rj_fwd"}, $sformatf("%0b", exp.rj_fwd),
                            $sformatf("%0b", act.rj_fwd));
        if (act.rk_fwd !== exp.rk_fwd)
            report_mismatch({unit, ".rk_fwd"}, $sformatf("%0b", exp.rk_fwd),
                            $sformatf("%0b", act.rk_fwd));
        if (act.stall !== exp.stall)
            report_mismatch({unit, ".stall"}, $sformatf("%0b", exp.stall),
                            $sformatf("%0b", act.stall));
    endtask

    task automatic check_comb();
        if (allowin_o !== ex2_allowin_i)
            report_mismatch("allowin_o", $sformatf("%0b", ex2_allowin_i),
                            $sformatf("%0b", allowin_o));
        if (stall_o !== exp_stall)
            report_mismatch("stall_o", $sformatf("%0b", exp_stall), $sformatf("%0b", stall_o));
        if (ready_go_o !== ~exp_stall)
            report_mismatch("ready_go_o", $sformatf("%0b", ~exp_stall),
                            $sformatf("%0b", ready_go_o));
        check_flags("fwd_lane0", dut0.fwd0, exp_fwd[0]);
        check_flags("fwd_lane1", dut0.fwd1, exp_fwd[1]);
        if (dreq_o.valid !== exp_dreq.valid)
            report_mismatch("dreq_o.valid", $sformatf("%0b", exp_dreq.valid),
                            $sformatf("%0b", dreq_o.valid));
        // fields only mean something with a live request
        if (exp_dreq.valid && dreq_o !== exp_dreq)
            report_mismatch("dreq_o", $sformatf("%0h", exp_dreq), $sformatf("%0h", dreq_o));
    endtask

    task automatic drive_random();
        logic [31:0] r;
        ex1_pkg::lane_t   ln;
        ex1_pkg::bypass_t b;
        r             = rand32();
        flush_i       = (r[3:0] == 4'd0);
        ex2_allowin_i = (r[5:4] != 2'b00);
        issue_i.valid = (r[7:6] != 2'b00);
        for (int l = 0; l < 2; l++) begin
            random_lane(ln);
            issue_i.lane[l] = ln;
        end
        for (int i = 0; i < `EX1_EX2_SLOTS; i++) begin
            random_bypass(b);
            ex2_byp_i[i] = b;
        end
        for (int i = 0; i < `EX1_WB_SLOTS; i++) begin
            random_bypass(b);
            wb_byp_i[i] = b;
        end
    endtask

    // model of the ex2 register, flush first
    task automatic update_model();
        if (flush_i && ex2_allowin_i) begin
            exp_out = nop_pkt;
            n_flush++;
        end else if (exp_transfer) begin
            exp_out.valid = issue_i.valid;
            exp_out.lane  = issue_i.lane;
            for (int l = 0; l < 2; l++) begin
                exp_out.lane[l].rj_data = exp_fwd[l].rj_data;
                exp_out.lane[l].rk_data = exp_fwd[l].rk_data;
            end
            n_transfer++;
        end
        if (exp_stall)
            n_stall++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at time %0t, the stimulus loop did not finish", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed          = 32'h59e3_08c6;
        errors        = 0;
        n_transfer    = 0;
        n_stall       = 0;
        n_flush       = 0;
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        issue_i       = '0;
        ex2_byp_i     = '0;
        wb_byp_i      = '0;
        ex2_allowin_i = 1'b0;
        nop_pkt              = '0;
        nop_pkt.lane[0].inst = `EX1_INST_NOP;
        nop_pkt.lane[1].inst = `EX1_INST_NOP;
        exp_out              = nop_pkt;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            // register output from the last rising edge
            if (ex1_out_o !== exp_out)
                report_mismatch("ex1_out_o", $sformatf("%0h", exp_out),
                                $sformatf("%0h", ex1_out_o));
            drive_random();
            #1;
            compute_expected();
            check_comb();
            update_model();
            @(negedge clk);
        end
        if (ex1_out_o !== exp_out)
            report_mismatch("ex1_out_o", $sformatf("%0h", exp_out), $sformatf("%0h", ex1_out_o));
        $display("cycles=%0d transfers=%0d stalls=%0d flushes=%0d errors=%0d",
                 NUM_CYCLES, n_transfer, n_stall, n_flush, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/ex1_pkg.sv
logic/ex1_operand_forward.sv
logic/ex1_stage_buffer.sv
logic/ex1_stage.sv
dv/ex1_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ex1_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(wildcard logic/*) $(wildcard dv/*)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
